// ==== apb_ctrl_regs.sv ====
// APB control and status registers
`timescale 1ns/100ps
`default_nettype none

module apb_ctrl_regs (
    input  logic                 aclk,
    input  logic                 areset_n,
    input  stream_pkg::apb_req_t apb_req,
    output stream_pkg::apb_rsp_t apb_rsp,
    output logic                 enable,
    output stream_pkg::gain_t    gain,
    output stream_pkg::offset_t  offset,
    input  logic                 beat_done,
    input  logic                 clip_flag
);
    import stream_pkg::*;

    logic   access;      // Access phase of any transfer
    logic   wr_en;       // Write committing this edge
    logic   mapped;      // Address decodes
    logic   wr_illegal;  // Write to read-only clip count
    logic   clear;       // Counter clear strobe
    count_t beat_count;
    count_t clip_count;

    assign access     = apb_req.psel && apb_req.penable;
    assign wr_illegal = apb_req.pwrite && apb_req.paddr == addr_clip_count;
    assign wr_en      = access && apb_req.pwrite && mapped && !wr_illegal;
    assign clear      = wr_en && apb_req.paddr == addr_beat_count;

    // Read mux and decode
    always_comb begin
        mapped         = 1'b1;
        apb_rsp.prdata = '0;
        case (apb_req.paddr)
            addr_ctrl:       apb_rsp.prdata = {31'b0, enable};
            addr_gain:       apb_rsp.prdata = 32'(gain);    // Sign extended
            addr_offset:     apb_rsp.prdata = 32'(offset);
            addr_beat_count: apb_rsp.prdata = beat_count;
            addr_clip_count: apb_rsp.prdata = clip_count;
            default:         mapped = 1'b0;
        endcase
    end

    // Error only in the access phase
    assign apb_rsp.pslverr = access && (!mapped || wr_illegal);

    // Writable registers
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            enable <= 1'b0;
            gain   <= gain_reset;
            offset <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                addr_ctrl:   enable <= apb_req.pwdata[0];
                addr_gain:   gain   <= apb_req.pwdata[15:0];
                addr_offset: offset <= apb_req.pwdata[15:0];
                default:     ;                            // Counters handled below
            endcase
        end
    end

    // Beat and clip counters
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            beat_count <= '0;
            clip_count <= '0;
        end else if (clear) begin
            beat_count <= '0;                         // Clear beats a same-cycle count
            clip_count <= '0;
        end else if (beat_done) begin
            beat_count <= beat_count + count_t'(1);
            if (clip_flag) begin
                clip_count <= clip_count + count_t'(1);
            end
        end
    end

    // Access phase always follows a selected setup phase
    a_penable_needs_psel: assert property (@(posedge aclk) disable iff (!areset_n)
        $rose(apb_req.penable) |-> apb_req.psel);

endmodule

`default_nettype wire

// ==== files.f ====
stream_pkg.sv
stream_delay.sv
stream_scale.sv
stream_clip.sv
apb_ctrl_regs.sv
stream_scaler_top.sv
tb_stream_scaler.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream scaler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_stream_scaler -o tb_stream_scaler
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_stream_scaler > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

// ==== stream_clip.sv ====
// Saturating output register stage
`timescale 1ns/100ps
`default_nettype none

module stream_clip (
    input  logic                   aclk,
    input  logic                   areset_n,
    input  logic                   rx_valid,
    input  logic signed [16:0]     rx_sum,
    input  logic                   rx_last,
    output logic                   rx_ready,
    output logic                   tx_valid,
    output stream_pkg::axis_beat_t tx_beat,
    input  logic                   tx_ready,
    output logic                   beat_done,
    output logic                   clip_flag
);
    import stream_pkg::*;

    localparam sample_t sample_max = 16'sh7FFF;   // 32767
    localparam sample_t sample_min = 16'sh8000;   // -32768

    sample_t sat_data;
    logic    sat_clip;

    assign rx_ready = tx_ready;

    always_comb begin
        sat_clip = 1'b1;
        if (rx_sum > 17'sd32767) begin
            sat_data = sample_max;                // Positive overflow
        end else if (rx_sum < -17'sd32768) begin
            sat_data = sample_min;                // Negative overflow
        end else begin
            sat_data = rx_sum[15:0];              // In range
            sat_clip = 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            tx_beat.data <= sat_data;
            tx_beat.last <= rx_last;
            clip_flag    <= sat_clip;             // Travels with the beat
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_valid <= 1'b0;
        end else if (tx_ready) begin
            tx_valid <= rx_valid;
        end
    end

    assign beat_done = tx_valid && tx_ready;      // Output handshake

    // Clipped beats sit on a limit
    a_clip_at_limit: assert property (@(posedge aclk) disable iff (!areset_n)
        tx_valid && clip_flag |-> tx_beat.data == sample_max || tx_beat.data == sample_min);

endmodule

`default_nettype wire

// ==== stream_delay.sv ====
// Stalling valid/data delay line
`timescale 1ns/100ps
`default_nettype none

module stream_delay #(
    parameter int DELAY_STAGES = 1                  // Number of register stages
) (
    input  logic                   aclk,
    input  logic                   areset_n,
    input  logic                   rx_valid,
    input  stream_pkg::axis_beat_t rx_beat,
    output logic                   rx_ready,
    output logic                   tx_valid,
    output stream_pkg::axis_beat_t tx_beat,
    input  logic                   tx_ready
);
    import stream_pkg::*;

    logic [DELAY_STAGES:0] q_valid;                 // Index 0 is the input
    axis_beat_t            q_beat [DELAY_STAGES:0];

    assign rx_ready   = tx_ready;                   // Whole line stalls together
    assign q_valid[0] = rx_valid;
    assign q_beat[0]  = rx_beat;

    for (genvar i = 0; i < DELAY_STAGES; i++) begin : g_stage
        always_ff @(posedge aclk or negedge areset_n) begin
            if (!areset_n) begin
                q_valid[i+1] <= 1'b0;               // Empty pipe
            end else if (tx_ready) begin
                q_valid[i+1] <= q_valid[i];         // Bubbles shift too
            end
        end

        always_ff @(posedge aclk) begin
            if (tx_ready) begin
                q_beat[i+1] <= q_beat[i];           // Payload, no reset
            end
        end
    end

    assign tx_valid = q_valid[DELAY_STAGES];
    assign tx_beat  = q_beat[DELAY_STAGES];

    // Offered beat must hold until taken
    a_hold_stalled: assert property (@(posedge aclk) disable iff (!areset_n)
        tx_valid && !tx_ready |=> $stable(tx_beat));

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
// Stream scaler shared types
`default_nettype none

package stream_pkg;

    typedef logic signed [15:0] sample_t;   // One signed sample
    typedef logic signed [15:0] gain_t;     // Q8.8, 0x0100 is unity
    typedef logic signed [15:0] offset_t;   // Added after scaling
    typedef logic signed [31:0] product_t;  // Full sample times gain
    typedef logic [31:0] count_t;           // Event counter

    typedef struct packed {
        sample_t data;                      // Sample payload
        logic    last;                      // End of packet marker
    } axis_beat_t;

    typedef struct packed {
        logic        psel;                  // Slave selected
        logic        penable;               // Access phase
        logic        pwrite;                // Write when high
        logic [7:0]  paddr;                 // Byte address
        logic [31:0] pwdata;                // Write data
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;                // Read data, access phase
        logic        pslverr;               // Unmapped or illegal access
    } apb_rsp_t;

    // Register map
    localparam logic [7:0] addr_ctrl       = 8'h00;  // Bit 0 enable
    localparam logic [7:0] addr_gain       = 8'h04;
    localparam logic [7:0] addr_offset     = 8'h08;
    localparam logic [7:0] addr_beat_count = 8'h0C;  // Write clears both counts
    localparam logic [7:0] addr_clip_count = 8'h10;  // Read only

    localparam gain_t gain_reset = 16'sh0100;        // Unity gain

endpackage

`default_nettype wire

// ==== stream_scale.sv ====
// Two-stage gain and offset pipeline
`timescale 1ns/100ps
`default_nettype none

module stream_scale (
    input  logic                   aclk,
    input  logic                   areset_n,
    input  logic                   rx_valid,
    input  stream_pkg::axis_beat_t rx_beat,
    output logic                   rx_ready,
    input  logic                   enable,
    input  stream_pkg::gain_t      gain,
    input  stream_pkg::offset_t    offset,
    output logic                   tx_valid,
    output logic signed [16:0]     tx_sum,
    output logic                   tx_last,
    input  logic                   tx_ready
);
    import stream_pkg::*;

    localparam logic signed [16:0] wide_max = 17'h0FFFF;  // Top of 17-bit range
    localparam logic signed [16:0] wide_min = 17'h10000;  // Bottom of 17-bit range

    logic               s1_valid;
    logic               s1_last;
    product_t           s1_product;   // Q8.8 scaled sample
    offset_t            s1_offset;    // Offset captured with the beat
    logic signed [31:0] full_sum;     // Cannot overflow at 32 bits
    logic signed [16:0] wide_sum;

    assign rx_ready = tx_ready;       // Same advance as downstream

    // Stage 1 multiply, or shift into Q8.8 when bypassed
    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            s1_last    <= rx_beat.last;
            s1_product <= enable ? rx_beat.data * gain : product_t'(rx_beat.data) <<< 8;
            s1_offset  <= enable ? offset : '0;   // No offset in bypass
        end
    end

    // Shift back down and add offset
    always_comb begin
        full_sum = (s1_product >>> 8) + product_t'(s1_offset);
        if (full_sum > 32'sd65535) begin
            wide_sum = wide_max;                  // Still far above sample max
        end else if (full_sum < -32'sd65536) begin
            wide_sum = wide_min;                  // Still far below sample min
        end else begin
            wide_sum = full_sum[16:0];
        end
    end

    // Stage 2 register
    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            tx_sum  <= wide_sum;
            tx_last <= s1_last;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            s1_valid <= 1'b0;
            tx_valid <= 1'b0;
        end else if (tx_ready) begin
            s1_valid <= rx_valid;
            tx_valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

// ==== stream_scaler_top.sv ====
// Stream gain stage top level
`timescale 1ns/100ps
`default_nettype none

module stream_scaler_top #(
    parameter int DELAY_STAGES = 1                 // Retiming stages before multiply
) (
    input  logic                   aclk,
    input  logic                   areset_n,
    input  stream_pkg::apb_req_t   apb_req,
    output stream_pkg::apb_rsp_t   apb_rsp,
    input  logic                   rx_valid,
    input  stream_pkg::axis_beat_t rx_beat,
    output logic                   rx_ready,
    output logic                   tx_valid,
    output stream_pkg::axis_beat_t tx_beat,
    input  logic                   tx_ready
);
    import stream_pkg::*;

    // Control to datapath
    logic    enable;
    gain_t   gain;
    offset_t offset;

    // Output status to counters
    logic beat_done;
    logic clip_flag;

    // Delay to scale
    logic       d_valid;
    axis_beat_t d_beat;
    logic       d_ready;

    // Scale to clip
    logic               s_valid;
    logic signed [16:0] s_sum;
    logic               s_last;
    logic               s_ready;

    apb_ctrl_regs u_regs (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .enable    (enable),
        .gain      (gain),
        .offset    (offset),
        .beat_done (beat_done),
        .clip_flag (clip_flag)
    );

    stream_delay #(
        .DELAY_STAGES (DELAY_STAGES)
    ) u_delay (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_valid (rx_valid),
        .rx_beat  (rx_beat),
        .rx_ready (rx_ready),
        .tx_valid (d_valid),
        .tx_beat  (d_beat),
        .tx_ready (d_ready)
    );

    stream_scale u_scale (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_valid (d_valid),
        .rx_beat  (d_beat),
        .rx_ready (d_ready),
        .enable   (enable),
        .gain     (gain),
        .offset   (offset),
        .tx_valid (s_valid),
        .tx_sum   (s_sum),
        .tx_last  (s_last),
        .tx_ready (s_ready)
    );

    stream_clip u_clip (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_valid  (s_valid),
        .rx_sum    (s_sum),
        .rx_last   (s_last),
        .rx_ready  (s_ready),
        .tx_valid  (tx_valid),
        .tx_beat   (tx_beat),
        .tx_ready  (tx_ready),
        .beat_done (beat_done),
        .clip_flag (clip_flag)
    );

endmodule

`default_nettype wire

// ==== tb_stream_scaler.sv ====
// Stream scaler directed testbench
`timescale 1ns/100ps
`default_nettype none

module tb_stream_scaler;
    import stream_pkg::*;

    localparam int timeout_cycles = 4000;   // Longest run is well under 1000 cycles

    logic       aclk = 1'b0;
    logic       areset_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       rx_valid;
    axis_beat_t rx_beat;
    logic       rx_ready;
    logic       tx_valid;
    axis_beat_t tx_beat;
    logic       tx_ready;

    logic [31:0] lfsr = 32'h7498;           // Fibonacci LFSR state
    string       cur_test = "reset";
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          model_clips = 0;           // Clipped beats since last clear
    logic        bp_on = 1'b0;              // Random tx_ready when set
    logic        cfg_enable = 1'b0;         // Model copy of the registers
    gain_t       cfg_gain = gain_reset;
    offset_t     cfg_offset = '0;
    axis_beat_t  stim_q[$];                 // Beats to send
    axis_beat_t  exp_q[$];                  // Model outputs, in order

    stream_scaler_top #(.DELAY_STAGES(2)) dut0 (
        .aclk(aclk), .areset_n(areset_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .rx_valid(rx_valid), .rx_beat(rx_beat), .rx_ready(rx_ready),
        .tx_valid(tx_valid), .tx_beat(tx_beat), .tx_ready(tx_ready)
    );

    always #10 aclk = ~aclk;                // 20 ns period

    // Taps 32 22 2 1 with one step per bit
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic void check_value(input string what, input logic [31:0] exp,
                                        input logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endfunction

    // Scale, shift, offset, then saturate
    function automatic sample_t model_sample(input sample_t s, output logic clipped);
        longint full;
        if (cfg_enable) begin
            full = ((longint'(s) * longint'(cfg_gain)) >>> 8) + longint'(cfg_offset);
        end else begin
            full = longint'(s);             // Bypass passes the sample through
        end
        clipped = 1'b1;
        if (full > 32767) begin
            full = 32767;
        end else if (full < -32768) begin
            full = -32768;
        end else begin
            clipped = 1'b0;
        end
        return sample_t'(full);
    endfunction

    task automatic next_cycle();
        @(posedge aclk);
        if (bp_on) begin
            tx_ready <= next_bit();         // Random back-pressure
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge aclk);
        apb_req.penable <= 1'b1;            // Access phase
        @(posedge aclk);
        err = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge aclk);
        apb_req.penable <= 1'b1;
        @(posedge aclk);
        data = apb_rsp.prdata;              // Valid in access phase
        err  = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic read_check(input string what, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value(what, exp, data);
        check_value({what, " pslverr"}, 32'h0, 32'(err));
    endtask

    task automatic configure(input logic en, input gain_t g, input offset_t off);
        logic err;
        apb_write(addr_gain, 32'(g), err);
        check_value("gain pslverr", 32'h0, 32'(err));
        apb_write(addr_offset, 32'(off), err);
        check_value("offset pslverr", 32'h0, 32'(err));
        apb_write(addr_ctrl, {31'b0, en}, err);
        check_value("ctrl pslverr", 32'h0, 32'(err));
        cfg_enable = en;
        cfg_gain   = g;
        cfg_offset = off;
    endtask

    task automatic clear_counts();
        logic err;
        apb_write(addr_beat_count, 32'h0, err);   // Clears both counters
        model_clips = 0;
    endtask

    task automatic send_and_check();
        logic    clipped;
        sample_t exp_data;
        foreach (stim_q[i]) begin
            exp_data = model_sample(stim_q[i].data, clipped);
            exp_q.push_back('{data: exp_data, last: stim_q[i].last});
            if (clipped) begin
                model_clips++;
            end
        end
        foreach (stim_q[i]) begin
            rx_valid <= 1'b1;
            rx_beat  <= stim_q[i];
            do next_cycle(); while (!rx_ready);   // Hold until taken
        end
        rx_valid <= 1'b0;
        while (exp_q.size() > 0) begin
            next_cycle();                   // Timeout catches a lost beat
        end
        stim_q.delete();
    endtask

    // Collector samples mid-cycle where outputs are stable
    always @(negedge aclk) begin
        axis_beat_t exp_beat;
        if (areset_n) begin
            assert (rx_ready == tx_ready) else begin
                errors++;
                $display("Fail %s rx_ready expected %b actual %b", cur_test, tx_ready, rx_ready);
            end
            if (tx_valid && tx_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("Output beat %h in %s was not expected", tx_beat.data, cur_test);
                end
                if (exp_q.size() > 0) begin
                    exp_beat = exp_q.pop_front();
                    check_value("data", 32'(exp_beat.data), 32'(tx_beat.data));
                    check_value("last", 32'(exp_beat.last), 32'(tx_beat.last));
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run stopped after %0d cycles in %s, output never completed", cycles,
                     cur_test);
            $display("Checks %0d, errors %0d", checks, errors + 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic test_register_reset();
        logic err;
        cur_test = "register_reset";
        read_check("ctrl", addr_ctrl, 32'h0);
        read_check("gain", addr_gain, 32'h0000_0100);
        read_check("offset", addr_offset, 32'h0);
        read_check("beat_count", addr_beat_count, 32'h0);
        read_check("clip_count", addr_clip_count, 32'h0);
        apb_write(addr_gain, 32'h0000_0234, err);
        read_check("gain readback", addr_gain, 32'h0000_0234);
        apb_write(addr_offset, 32'hFFFF_FF9C, err);   // -100
        read_check("offset readback", addr_offset, 32'hFFFF_FF9C);
        apb_write(addr_ctrl, 32'h1, err);
        read_check("ctrl readback", addr_ctrl, 32'h1);
        configure(1'b0, gain_reset, '0);    // Back to reset values
    endtask

    task automatic test_bypass();
        cur_test = "bypass";
        for (int i = 0; i < 20; i++) begin
            stim_q.push_back('{data: sample_t'(rand_bits(16)), last: (i % 10) == 9});
        end
        send_and_check();
        read_check("beat_count", addr_beat_count, 32'd20);
    endtask

    task automatic test_scaling();
        cur_test = "scaling";
        configure(1'b1, 16'sh0180, -16'sd100);
        for (int i = 0; i < 30; i++) begin
            stim_q.push_back('{data: sample_t'(rand_bits(16)), last: i == 29});
        end
        send_and_check();
    endtask

    task automatic test_saturation();
        sample_t vals[10];
        cur_test = "saturation";
        vals = '{20000, -20000, 32767, -32768, 100, -100, 8191, 8192, -8192, -8193};
        clear_counts();
        configure(1'b1, 16'sh0400, '0);     // Gain of 4
        foreach (vals[i]) begin
            stim_q.push_back('{data: vals[i], last: i == 9});
        end
        send_and_check();
        read_check("clip_count", addr_clip_count, 32'(model_clips));
        read_check("beat_count", addr_beat_count, 32'd10);
        clear_counts();
        read_check("beat_count cleared", addr_beat_count, 32'h0);
        read_check("clip_count cleared", addr_clip_count, 32'h0);
    endtask

    task automatic test_back_pressure();
        cur_test = "back_pressure";
        clear_counts();
        configure(1'b1, 16'sh00C0, 16'sd25);
        for (int i = 0; i < 50; i++) begin
            stim_q.push_back('{data: sample_t'(rand_bits(16)), last: (i % 10) == 9});
        end
        bp_on = 1'b1;
        send_and_check();
        bp_on = 1'b0;
        tx_ready <= 1'b1;
        read_check("beat_count", addr_beat_count, 32'd50);
    endtask

    task automatic test_slave_errors();
        logic [31:0] data;
        logic        err;
        cur_test = "slave_errors";
        apb_read(8'h14, data, err);         // Unmapped
        check_value("unmapped pslverr", 32'h1, 32'(err));
        apb_write(addr_clip_count, 32'h55, err);
        check_value("clip write pslverr", 32'h1, 32'(err));
        read_check("clip_count kept", addr_clip_count, 32'(model_clips));
        read_check("beat_count kept", addr_beat_count, 32'd50);
        read_check("ctrl kept", addr_ctrl, {31'b0, cfg_enable});
        read_check("gain kept", addr_gain, 32'(cfg_gain));
        read_check("offset kept", addr_offset, 32'(cfg_offset));
    endtask

    initial begin
        areset_n = 1'b0;
        apb_req  = '0;
        rx_valid = 1'b0;
        rx_beat  = '0;
        tx_ready = 1'b1;
        repeat (3) @(posedge aclk);         // Reset for 3 cycles
        areset_n <= 1'b1;
        @(posedge aclk);
        test_register_reset();
        test_bypass();
        test_scaling();
        test_saturation();
        test_back_pressure();
        test_slave_errors();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
